/* source/key_schedule_pkg.sv */
package key_schedule_pkg;

   // key and word sizes, AES-128 only
   localparam int WORD_W = 32;
   localparam int KEY_WORDS = 4;

   // ten generated rounds plus the cipher key itself as round 0
   localparam int NUM_ROUNDS = 10;
   localparam int NUM_ROUND_KEYS = NUM_ROUNDS + 1;
   localparam int ROUND_IDX_W = $clog2(NUM_ROUND_KEYS);

   // round constant starts at 01 and doubles in GF(2^8)
   localparam logic [7:0] RCON_FIRST = 8'h01;
   localparam logic [7:0] RCON_POLY = 8'h1b;

   typedef logic [WORD_W-1:0] word_t;

   // w0 sits in the top 32 bits, same order as the cipher key
   typedef struct packed {
      word_t w0;
      word_t w1;
      word_t w2;
      word_t w3;
   } round_key_t;

   typedef logic [ROUND_IDX_W-1:0] round_idx_t;

endpackage

/* source/sub_word.sv */
module sub_word
   import key_schedule_pkg::*;
(
   input  word_t i_word,
   output word_t o_word
);

   // one S-box row selected by the high nibble of the input byte
   function automatic logic [0:15][7:0] sbox_row(input logic [3:0] row);
      case (row)
         // row 0 holds inputs 00 to 0f
         4'h0: return 128'h637c777bf26b6fc53001672bfed7ab76;
         // row 1
         4'h1: return 128'hca82c97dfa5947f0add4a2af9ca472c0;
         // row 2
         4'h2: return 128'hb7fd9326363ff7cc34a5e5f171d83115;
         // row 3
         4'h3: return 128'h04c723c31896059a071280e2eb27b275;
         // row 4
         4'h4: return 128'h09832c1a1b6e5aa0523bd6b329e32f84;
         // row 5
         4'h5: return 128'h53d100ed20fcb15b6acbbe394a4c58cf;
         // row 6
         4'h6: return 128'hd0efaafb434d338545f9027f503c9fa8;
         // row 7
         4'h7: return 128'h51a3408f929d38f5bcb6da2110fff3d2;
         // row 8
         4'h8: return 128'hcd0c13ec5f974417c4a77e3d645d1973;
         // row 9
         4'h9: return 128'h60814fdc222a908846eeb814de5e0bdb;
         // row a
         4'ha: return 128'he0323a0a4906245cc2d3ac629195e479;
         // row b
         4'hb: return 128'he7c8376d8dd54ea96c56f4ea657aae08;
         // row c
         4'hc: return 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
         // row d
         4'hd: return 128'h703eb5664803f60e613557b986c11d9e;
         // row e
         4'he: return 128'he1f8981169d98e949b1e87e9ce5528df;
         // row f holds inputs f0 to ff
         default: return 128'h8ca1890dbfe6426841992d0fb054bb16;
      endcase
   endfunction

   // low nibble picks the byte within the row where byte 0 is leftmost
   function automatic logic [7:0] sbox(input logic [7:0] in_byte);
      logic [0:15][7:0] row_bytes;
      row_bytes = sbox_row(in_byte[7:4]);
      return row_bytes[in_byte[3:0]];
   endfunction

   // each byte lane is looked up on its own
   for (genvar b = 0; b < WORD_W / 8; b++) begin : g_byte
      assign o_word[b*8 +: 8] = sbox(i_word[b*8 +: 8]);
   end

endmodule

/* source/key_schedule_ctrl.sv */
module key_schedule_ctrl
   import key_schedule_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset,
   input  logic       i_key_load,
   output logic       o_load_start,
   output logic       o_gen_active,
   output logic       o_wr_en,
   output round_idx_t o_wr_idx,
   output logic       o_done
);

   round_idx_t round_cnt_q;
   logic       gen_active_q;
   logic       done_q;
   logic       last_round;

   // a load is taken on any cycle, even in the middle of a run
   assign o_load_start = i_key_load;

   // load cycle writes entry 0, then one entry per generating cycle
   assign o_wr_en = i_key_load | gen_active_q;
   assign o_wr_idx = i_key_load ? '0 : round_cnt_q;

   assign last_round = (round_cnt_q == round_idx_t'(NUM_ROUNDS));

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         round_cnt_q <= '0;
         gen_active_q <= 1'b0;
         done_q <= 1'b0;
      end else if (i_key_load) begin
         // restart from round 1 regardless of where a previous run was
         round_cnt_q <= round_idx_t'(1);
         gen_active_q <= 1'b1;
         done_q <= 1'b0;
      end else if (gen_active_q) begin
         if (last_round) begin
            gen_active_q <= 1'b0;
            done_q <= 1'b1;
         end else begin
            round_cnt_q <= round_cnt_q + 1'b1;
         end
      end
   end

   assign o_gen_active = gen_active_q;
   assign o_done = done_q;

endmodule

/* source/round_key_step.sv */
module round_key_step
   import key_schedule_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset,
   input  logic       i_load_start,
   input  logic       i_gen_active,
   input  round_key_t i_cypher_key,
   output round_key_t o_next_key
);

   round_key_t work_q;
   logic [7:0] rcon_q;
   logic [7:0] rcon_dbl;
   word_t      rot_w;
   word_t      sub_w;
   word_t      lead_w;

   // same 128 bits as the struct, w0 at index 0
   word_t [0:KEY_WORDS-1] cur_words;
   word_t [0:KEY_WORDS-1] new_words;

   assign cur_words = work_q;

   // RotWord on the last word of the previous round key
   assign rot_w = {work_q.w3[WORD_W-9:0], work_q.w3[WORD_W-1 -: 8]};

   sub_word sub_word_i (
      .i_word (rot_w),
      .o_word (sub_w)
   );

   // round constant only touches the top byte
   assign lead_w = sub_w ^ {rcon_q, {(WORD_W - 8){1'b0}}};

   // first word takes the transformed word, the rest chain off their neighbour
   always_comb begin
      new_words[0] = cur_words[0] ^ lead_w;
      for (int i = 1; i < KEY_WORDS; i++) begin
         new_words[i] = cur_words[i] ^ new_words[i-1];
      end
   end

   assign o_next_key = round_key_t'(new_words);

   // xtime, with reduction when the top bit falls off
   assign rcon_dbl = rcon_q[7] ? ({rcon_q[6:0], 1'b0} ^ RCON_POLY) : {rcon_q[6:0], 1'b0};

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rcon_q <= RCON_FIRST;
      end else if (i_load_start) begin
         rcon_q <= RCON_FIRST;
      end else if (i_gen_active) begin
         rcon_q <= rcon_dbl;
      end
   end

   // working key, only meaningful once a load has happened
   always_ff @(posedge i_clk) begin
      if (i_load_start) begin
         work_q <= i_cypher_key;
      end else if (i_gen_active) begin
         work_q <= o_next_key;
      end
   end

endmodule

/* source/round_key_store.sv */
module round_key_store
   import key_schedule_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset,
   input  logic       i_wr_en,
   input  round_idx_t i_wr_idx,
   input  round_key_t i_wr_key,
   input  round_idx_t i_rd_idx,
   output round_key_t o_rd_key
);

   round_key_t key_mem [NUM_ROUND_KEYS];
   round_key_t rd_key_q;
   logic       wr_ok;
   logic       rd_ok;

   // indices 11 to 15 fall outside the table
   assign wr_ok = i_wr_en && (int'(i_wr_idx) < NUM_ROUND_KEYS);
   assign rd_ok = (int'(i_rd_idx) < NUM_ROUND_KEYS);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 0; i < NUM_ROUND_KEYS; i++) begin
            key_mem[i] <= '0;
         end
         rd_key_q <= '0;
      end else begin
         if (wr_ok) begin
            key_mem[i_wr_idx] <= i_wr_key;
         end
         // read samples the old entry when the same index is written
         if (rd_ok) begin
            rd_key_q <= key_mem[i_rd_idx];
         end else begin
            rd_key_q <= '0;
         end
      end
   end

   assign o_rd_key = rd_key_q;

endmodule

/* source/key_schedule_top.sv */
module key_schedule_top
   import key_schedule_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset,
   input  logic       i_key_load,
   input  round_key_t i_cypher_key,
   input  round_idx_t i_round_sel,
   output round_key_t o_round_key,
   output logic       o_done
);

   logic       load_start;
   logic       gen_active;
   logic       wr_en;
   round_idx_t wr_idx;
   round_key_t next_key;
   round_key_t wr_key;

   key_schedule_ctrl key_schedule_ctrl_i (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_key_load   (i_key_load),
      .o_load_start (load_start),
      .o_gen_active (gen_active),
      .o_wr_en      (wr_en),
      .o_wr_idx     (wr_idx),
      .o_done       (o_done)
   );

   round_key_step round_key_step_i (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_load_start (load_start),
      .i_gen_active (gen_active),
      .i_cypher_key (i_cypher_key),
      .o_next_key   (next_key)
   );

   // entry 0 is the cipher key itself, later entries come from the step
   assign wr_key = load_start ? i_cypher_key : next_key;

   round_key_store round_key_store_i (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_wr_en  (wr_en),
      .i_wr_idx (wr_idx),
      .i_wr_key (wr_key),
      .i_rd_idx (i_round_sel),
      .o_rd_key (o_round_key)
   );

endmodule

/* dv/key_schedule_tb.sv */
module key_schedule_tb
   import key_schedule_pkg::*;
();

   localparam int NUM_VECS = 4;
   localparam int MAX_CYCLES = NUM_VECS * 40 + 100;
   localparam int DRIVE_DLY = 2;
   // local bound on the wait for done well past the fixed latency
   localparam int DONE_LIMIT = 2 * NUM_ROUNDS;

   // one table row holds the cipher key, expected round 1 and round 10 keys and restart flag
   typedef struct packed {
      round_key_t key;
      round_key_t rk1;
      round_key_t rk10;
      logic       restart;
   } vector_t;

   logic       i_clk;
   logic       i_reset;
   logic       i_key_load;
   round_key_t i_cypher_key;
   round_idx_t i_round_sel;
   round_key_t o_round_key;
   logic       o_done;

   vector_t vectors [NUM_VECS];
   int      err_cnt;
   int      check_cnt;
   int      cycle_cnt;
   integer  seed;

   key_schedule_top key_schedule_top_i (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_key_load   (i_key_load),
      .i_cypher_key (i_cypher_key),
      .i_round_sel  (i_round_sel),
      .o_round_key  (o_round_key),
      .o_done       (o_done)
   );

   always #20 i_clk = ~i_clk;

   // published AES-128 expansion vectors
   task automatic build_vector_table();
      // FIPS-197 appendix A key
      vectors[0].key     = 128'h2b7e151628aed2a6abf7158809cf4f3c;
      vectors[0].rk1     = 128'ha0fafe1788542cb123a339392a6c7605;
      vectors[0].rk10    = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;
      vectors[0].restart = 1'b0;
      // all zeros and afterwards interrupted by a reload with the next row's key
      vectors[1].key     = 128'h00000000000000000000000000000000;
      vectors[1].rk1     = 128'h62636363626363636263636362636363;
      vectors[1].rk10    = 128'hb4ef5bcb3e92e21123e951cf6f8f188e;
      vectors[1].restart = 1'b1;
      // all ones
      vectors[2].key     = 128'hffffffffffffffffffffffffffffffff;
      vectors[2].rk1     = 128'he8e9e9e917161616e8e9e9e917161616;
      vectors[2].rk10    = 128'hd60a3588e472f07b82d2d7858cd7c326;
      vectors[2].restart = 1'b0;
      // FIPS-197 appendix C.1 key
      vectors[3].key     = 128'h000102030405060708090a0b0c0d0e0f;
      vectors[3].rk1     = 128'hd6aa74fdd2af72fadaa678f1d6ab76fe;
      vectors[3].rk10    = 128'h13111d7fe3944a17f307a78b4d2b30c5;
      vectors[3].restart = 1'b0;
   endtask

   // inputs change a little after the rising edge when outputs have settled
   task automatic next_cycle();
      @(posedge i_clk);
      #DRIVE_DLY;
   endtask

   task automatic compare_key(input string what, input round_key_t got,
                              input round_key_t exp);
      check_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic verify_flag(input string what, input logic got, input logic exp);
      check_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // drives the strobe for one edge and then scrambles the key bus
   task automatic load_key(input round_key_t key);
      i_key_load = 1'b1;
      i_cypher_key = key;
      next_cycle();
      i_key_load = 1'b0;
      // the key must have been taken on the load edge only
      i_cypher_key = {$random(seed), $random(seed), $random(seed), $random(seed)};
      verify_flag("o_done right after the load edge", o_done, 1'b0);
   endtask

   // result appears one edge after the index is sampled
   task automatic read_round_key(input round_idx_t idx, output round_key_t key);
      i_round_sel = idx;
      next_cycle();
      key = o_round_key;
   endtask

   // counts edges after the load edge until done rises
   task automatic count_edges_to_done(output int edges);
      int n;
      n = 0;
      while (o_done !== 1'b1 && n < DONE_LIMIT) begin
         next_cycle();
         n++;
      end
      edges = n;
   endtask

   // waits for done after the last load and reads back rounds 0, 1 and 10
   task automatic check_run(input int idx, input vector_t exp_vec);
      round_key_t got;
      int         edges;
      string      tag;
      count_edges_to_done(edges);
      check_cnt++;
      assert (edges == NUM_ROUNDS) else begin
         err_cnt++;
         $display("[ERROR] %0t: row %0d done after %0d edges, expected %0d",
                  $time, idx, edges, NUM_ROUNDS);
      end
      read_round_key(round_idx_t'(0), got);
      tag = $sformatf("row %0d round 0 key", idx);
      compare_key(tag, got, exp_vec.key);
      read_round_key(round_idx_t'(1), got);
      tag = $sformatf("row %0d round 1 key", idx);
      compare_key(tag, got, exp_vec.rk1);
      read_round_key(round_idx_t'(NUM_ROUNDS), got);
      tag = $sformatf("row %0d round 10 key", idx);
      compare_key(tag, got, exp_vec.rk10);
      // done is a level and holds until the next load
      verify_flag("o_done after the reads", o_done, 1'b1);
   endtask

   task automatic run_vector(input int idx);
      load_key(vectors[idx].key);
      check_run(idx, vectors[idx]);
      if (vectors[idx].restart) begin
         load_key(vectors[idx].key);
         // second load edge falls 3 cycles after the first
         repeat (2) begin
            next_cycle();
            verify_flag("o_done before the reload", o_done, 1'b0);
         end
         load_key(vectors[idx + 1].key);
         check_run(idx, vectors[idx + 1]);
      end
   endtask

   // stops a run that never reaches its summary
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles, %0d errors so far",
               MAX_CYCLES, err_cnt);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      round_key_t got;
      i_clk = 1'b0;
      i_reset = 1'b1;
      i_key_load = 1'b0;
      i_cypher_key = '0;
      i_round_sel = '0;
      err_cnt = 0;
      check_cnt = 0;
      seed = 32'h97a07bd8;
      build_vector_table();

      repeat (3) next_cycle();
      i_reset = 1'b0;

      // state right after reset
      verify_flag("o_done after reset", o_done, 1'b0);
      compare_key("o_round_key after reset", o_round_key, '0);
      read_round_key(round_idx_t'(5), got);
      compare_key("entry 5 after reset", got, '0);
      verify_flag("o_done while idle", o_done, 1'b0);

      for (int v = 0; v < NUM_VECS; v++) begin
         run_vector(v);
      end

      $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* key_schedule.f */
source/key_schedule_pkg.sv
source/sub_word.sv
source/key_schedule_ctrl.sv
source/round_key_step.sv
source/round_key_store.sv
source/key_schedule_top.sv
dv/key_schedule_tb.sv
